/* design/auth_pkg.sv */
package auth_pkg;

    localparam int WORD_BYTES = 64;
    localparam int BLOCK_BYTES = 16;
    localparam int BLOCKS_PER_WORD = WORD_BYTES / BLOCK_BYTES;
    localparam int KEY_IDX_W = 32;

    localparam int WORD_W = WORD_BYTES * 8;
    localparam int BLOCK_W = BLOCK_BYTES * 8;

    // one beat of the 512-bit message stream
    typedef struct packed {
        logic [WORD_W-1:0]     data;
        logic [WORD_BYTES-1:0] keep;
        logic                  last;
    } stream_word_t;

    // one 128-bit mixing block
    typedef struct packed {
        logic [BLOCK_W-1:0]     data;
        logic [BLOCK_BYTES-1:0] keep;
        logic                   last;
    } block_t;

    // header fields, cmd_id sits at bit 0
    typedef struct packed {
        logic [WORD_W-193:0] pad;
        logic [31:0]         data_len;
        logic [31:0]         tag;
        logic [31:0]         src;
        logic [31:0]         dst;
        logic [31:0]         cmd_len;
        logic [31:0]         cmd_id;
    } msg_header_t;

    typedef struct packed {
        logic [WORD_W-257:0]      pad;
        logic [BLOCK_W-1:0]       key;
        logic [127-KEY_IDX_W:0]   reserved;
        logic [KEY_IDX_W-1:0]     key_idx;
    } key_load_t;

    // the same input word seen as raw data, as a header or as a key record
    typedef union packed {
        logic [WORD_W-1:0] raw;
        msg_header_t       hdr;
        key_load_t         key_load;
    } in_word_u;

endpackage

/* design/stream_fifo.sv */
module stream_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             wr_en;
    logic             rd_en;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid & in_ready;
    assign rd_en     = out_valid & out_ready;

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/msg_splitter.sv */
module msg_splitter (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  auth_pkg::stream_word_t          in_word,
    input  logic                            in_key_load,
    output logic                            key_wr,
    output logic [auth_pkg::KEY_IDX_W-1:0]  key_wr_idx,
    output logic [auth_pkg::BLOCK_W-1:0]    key_wr_key,
    output logic                            hdr_valid,
    input  logic                            hdr_ready,
    output auth_pkg::stream_word_t          hdr_word,
    output logic                            idx_valid,
    input  logic                            idx_ready,
    output logic [auth_pkg::KEY_IDX_W-1:0]  idx_data,
    output logic                            pay_valid,
    input  logic                            pay_ready,
    output auth_pkg::stream_word_t          pay_word
);

    import auth_pkg::*;

    in_word_u view;
    logic     hdr_expected;
    logic     is_hdr;
    logic     is_pay;
    logic     in_fire;

    assign view = in_word.data;

    assign is_hdr  = !in_key_load & hdr_expected;
    assign is_pay  = !in_key_load & !hdr_expected;

    // key records never stall, a header needs room in both meta queues
    assign in_ready = in_key_load | (hdr_expected ? (hdr_ready & idx_ready) : pay_ready);
    assign in_fire  = in_valid & in_ready;

    assign key_wr     = in_valid & in_key_load;
    assign key_wr_idx = view.key_load.key_idx;
    assign key_wr_key = view.key_load.key;

    // header and index are pushed together or not at all
    assign hdr_valid = in_valid & is_hdr & idx_ready;
    assign hdr_word  = in_word;
    assign idx_valid = in_valid & is_hdr & hdr_ready;
    assign idx_data  = view.hdr.dst;

    assign pay_valid = in_valid & is_pay;
    assign pay_word  = in_word;

    // first message word after reset or after a last payload word is a header
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hdr_expected <= 1'b1;
        end else if (in_fire & is_hdr) begin
            hdr_expected <= 1'b0;
        end else if (in_fire & is_pay & in_word.last) begin
            hdr_expected <= 1'b1;
        end
    end

endmodule

/* design/key_table.sv */
module key_table #(
    parameter int NUM_KEYS = 16
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            key_wr,
    input  logic [auth_pkg::KEY_IDX_W-1:0]  key_wr_idx,
    input  logic [auth_pkg::BLOCK_W-1:0]    key_wr_key,
    input  logic [auth_pkg::KEY_IDX_W-1:0]  rd_idx,
    output logic [auth_pkg::BLOCK_W-1:0]    rd_key
);

    import auth_pkg::*;

    localparam int SEL_W = (NUM_KEYS > 1) ? $clog2(NUM_KEYS) : 1;

    logic [BLOCK_W-1:0] keys [NUM_KEYS];

    // only the low index bits select a key
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < NUM_KEYS; i++) begin
                keys[i] <= '0;
            end
        end else if (key_wr) begin
            keys[key_wr_idx[SEL_W-1:0]] <= key_wr_key;
        end
    end

    assign rd_key = keys[rd_idx[SEL_W-1:0]];

endmodule

/* design/block_unpacker.sv */
module block_unpacker (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  auth_pkg::stream_word_t in_word,
    output logic                   out_valid,
    input  logic                   out_ready,
    output auth_pkg::block_t       out_block
);

    import auth_pkg::*;

    localparam int SEL_W = $clog2(BLOCKS_PER_WORD);
    localparam logic [SEL_W-1:0] LAST_SEL = SEL_W'(BLOCKS_PER_WORD - 1);

    logic [SEL_W-1:0]           sel;
    logic [BLOCKS_PER_WORD-1:0] slice_used;
    logic                       has_next;
    logic                       out_fire;

    always_comb begin
        for (int i = 0; i < BLOCKS_PER_WORD; i++) begin
            slice_used[i] = |in_word.keep[i*BLOCK_BYTES +: BLOCK_BYTES];
        end
    end

    // keep is contiguous, so the first empty slice ends the word
    assign has_next  = (sel != LAST_SEL) && slice_used[sel + 1'b1];
    assign out_valid = in_valid & slice_used[sel];
    assign out_fire  = out_valid & out_ready;

    // a word with no kept bytes yields no block and is dropped
    assign in_ready = (out_fire & !has_next) | (in_valid & !slice_used[sel]);

    assign out_block.data = in_word.data[sel*BLOCK_W +: BLOCK_W];
    assign out_block.keep = in_word.keep[sel*BLOCK_BYTES +: BLOCK_BYTES];
    assign out_block.last = in_word.last & !has_next;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            sel <= '0;
        end else if (out_fire) begin
            sel <= has_next ? sel + 1'b1 : '0;
        end
    end

endmodule

/* design/key_mixer.sv */
module key_mixer (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  auth_pkg::block_t                in_block,
    input  logic                            idx_valid,
    output logic                            idx_ready,
    input  logic [auth_pkg::KEY_IDX_W-1:0]  idx_data,
    output logic [auth_pkg::KEY_IDX_W-1:0]  key_idx,
    input  logic [auth_pkg::BLOCK_W-1:0]    key,
    output logic                            out_valid,
    input  logic                            out_ready,
    output auth_pkg::block_t                out_block
);

    logic in_fire;

    // no block moves until its message index is queued
    assign in_ready  = idx_valid & (!out_valid | out_ready);
    assign in_fire   = in_valid & in_ready;

    // the index stays at the queue head for the whole message
    assign key_idx   = idx_data;
    assign idx_ready = in_fire & in_block.last;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_fire) begin
            out_block.data <= in_block.data ^ key;
            out_block.keep <= in_block.keep;
            out_block.last <= in_block.last;
        end
    end

endmodule

/* design/packet_merger.sv */
module packet_merger (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  auth_pkg::stream_word_t hdr_word,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  auth_pkg::block_t       in_block,
    output logic                   out_valid,
    input  logic                   out_ready,
    output auth_pkg::stream_word_t out_word
);

    import auth_pkg::*;

    localparam logic ST_HDR  = 1'b0;
    localparam logic ST_DATA = 1'b1;

    localparam int SLOT_W = $clog2(BLOCKS_PER_WORD);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(BLOCKS_PER_WORD - 1);

    logic              state;
    logic [SLOT_W-1:0] slot;
    logic              can_fill;
    logic              out_fire;
    logic              hdr_fire;
    logic              in_fire;
    logic              word_done;
    stream_word_t      fill_word;

    assign out_fire = out_valid & out_ready;
    assign can_fill = !out_valid | out_ready;

    assign hdr_ready = (state == ST_HDR) & can_fill;
    // the last word of a message must leave before the next header is taken
    assign in_ready  = (state == ST_DATA) & (!out_valid | (out_ready & !out_word.last));

    assign hdr_fire  = hdr_valid & hdr_ready;
    assign in_fire   = in_valid & in_ready;
    assign word_done = (slot == LAST_SLOT) | in_block.last;

    // slot 0 starts a fresh word, later slots add to the one being built
    always_comb begin
        fill_word = (slot == '0) ? '0 : out_word;
        fill_word.data[slot*BLOCK_W +: BLOCK_W] = in_block.data;
        fill_word.keep[slot*BLOCK_BYTES +: BLOCK_BYTES] = in_block.keep;
        fill_word.last = in_block.last;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= ST_HDR;
            slot      <= '0;
            out_valid <= 1'b0;
        end else begin
            if (hdr_fire) begin
                out_valid <= 1'b1;
                state     <= ST_DATA;
                slot      <= '0;
            end else if (in_fire) begin
                out_valid <= word_done;
                slot      <= word_done ? '0 : slot + 1'b1;
            end else if (out_fire) begin
                out_valid <= 1'b0;
            end
            if (out_fire & out_word.last) begin
                state <= ST_HDR;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (hdr_fire) begin
            out_word.data <= hdr_word.data;
            out_word.keep <= hdr_word.keep;
            out_word.last <= 1'b0;
        end else if (in_fire) begin
            out_word <= fill_word;
        end
    end

endmodule

/* design/auth_pipe.sv */
module auth_pipe #(
    parameter int PAYLOAD_DEPTH = 16,
    parameter int META_DEPTH    = 4,
    parameter int NUM_KEYS      = 16
) (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  auth_pkg::stream_word_t in_word,
    input  logic                   in_key_load,
    output logic                   out_valid,
    input  logic                   out_ready,
    output auth_pkg::stream_word_t out_word
);

    import auth_pkg::*;

    localparam int SW_W = $bits(stream_word_t);

    logic                 key_wr;
    logic [KEY_IDX_W-1:0] key_wr_idx;
    logic [BLOCK_W-1:0]   key_wr_key;
    logic [KEY_IDX_W-1:0] rd_idx;
    logic [BLOCK_W-1:0]   rd_key;

    // splitter side of the three queues
    logic                 hdr_in_valid;
    logic                 hdr_in_ready;
    stream_word_t         hdr_in_word;
    logic                 idx_in_valid;
    logic                 idx_in_ready;
    logic [KEY_IDX_W-1:0] idx_in_data;
    logic                 pay_in_valid;
    logic                 pay_in_ready;
    stream_word_t         pay_in_word;

    // consumer side of the three queues
    logic                 hdr_out_valid;
    logic                 hdr_out_ready;
    stream_word_t         hdr_out_word;
    logic                 idx_out_valid;
    logic                 idx_out_ready;
    logic [KEY_IDX_W-1:0] idx_out_data;
    logic                 pay_out_valid;
    logic                 pay_out_ready;
    stream_word_t         pay_out_word;

    logic                 blk_valid;
    logic                 blk_ready;
    block_t               blk;
    logic                 mix_valid;
    logic                 mix_ready;
    block_t               mix_blk;

    msg_splitter i_msg_splitter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_word     (in_word),
        .in_key_load (in_key_load),
        .key_wr      (key_wr),
        .key_wr_idx  (key_wr_idx),
        .key_wr_key  (key_wr_key),
        .hdr_valid   (hdr_in_valid),
        .hdr_ready   (hdr_in_ready),
        .hdr_word    (hdr_in_word),
        .idx_valid   (idx_in_valid),
        .idx_ready   (idx_in_ready),
        .idx_data    (idx_in_data),
        .pay_valid   (pay_in_valid),
        .pay_ready   (pay_in_ready),
        .pay_word    (pay_in_word)
    );

    stream_fifo #(.WIDTH(SW_W), .DEPTH(PAYLOAD_DEPTH)) payload_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (pay_in_valid),
        .in_ready  (pay_in_ready),
        .in_data   (pay_in_word),
        .out_valid (pay_out_valid),
        .out_ready (pay_out_ready),
        .out_data  (pay_out_word)
    );

    stream_fifo #(.WIDTH(SW_W), .DEPTH(META_DEPTH)) header_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (hdr_in_valid),
        .in_ready  (hdr_in_ready),
        .in_data   (hdr_in_word),
        .out_valid (hdr_out_valid),
        .out_ready (hdr_out_ready),
        .out_data  (hdr_out_word)
    );

    stream_fifo #(.WIDTH(KEY_IDX_W), .DEPTH(META_DEPTH)) index_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (idx_in_valid),
        .in_ready  (idx_in_ready),
        .in_data   (idx_in_data),
        .out_valid (idx_out_valid),
        .out_ready (idx_out_ready),
        .out_data  (idx_out_data)
    );

    key_table #(.NUM_KEYS(NUM_KEYS)) i_key_table (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .key_wr     (key_wr),
        .key_wr_idx (key_wr_idx),
        .key_wr_key (key_wr_key),
        .rd_idx     (rd_idx),
        .rd_key     (rd_key)
    );

    block_unpacker i_block_unpacker (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (pay_out_valid),
        .in_ready  (pay_out_ready),
        .in_word   (pay_out_word),
        .out_valid (blk_valid),
        .out_ready (blk_ready),
        .out_block (blk)
    );

    key_mixer i_key_mixer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (blk_valid),
        .in_ready  (blk_ready),
        .in_block  (blk),
        .idx_valid (idx_out_valid),
        .idx_ready (idx_out_ready),
        .idx_data  (idx_out_data),
        .key_idx   (rd_idx),
        .key       (rd_key),
        .out_valid (mix_valid),
        .out_ready (mix_ready),
        .out_block (mix_blk)
    );

    packet_merger i_packet_merger (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .hdr_valid (hdr_out_valid),
        .hdr_ready (hdr_out_ready),
        .hdr_word  (hdr_out_word),
        .in_valid  (mix_valid),
        .in_ready  (mix_ready),
        .in_block  (mix_blk),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

endmodule

/* tests/tb_auth_pipe.sv */
module tb_auth_pipe;

    import auth_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_KEYS     = 16;
    localparam int BP_MESSAGES  = 8;
    localparam int MAX_PAYLOAD  = 4;
    localparam int DRAIN_CYCLES = 400;
    localparam logic [31:0] SEED = 32'hca02_cf19;
    // input words of all tests, counted with the longest random messages
    localparam int MAX_WORDS      = 4 + 4 + 7 + 4 + BP_MESSAGES * (1 + MAX_PAYLOAD);
    localparam int TIMEOUT_CYCLES = MAX_WORDS * 20 + 1000;

    logic         aclk;
    logic         aresetn;
    logic         in_valid;
    logic         in_ready;
    stream_word_t in_word;
    logic         in_key_load;
    logic         out_valid;
    logic         out_ready;
    stream_word_t out_word;

    logic [31:0]        stim_rng;
    logic [31:0]        ready_rng;
    logic               random_ready;
    logic [BLOCK_W-1:0] key_model [NUM_KEYS];
    stream_word_t       exp_q [$];
    stream_word_t       exp_w;
    stream_word_t       held_word;
    logic               hold_pending;
    int                 words_checked;

    auth_pipe i_auth_pipe (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_word     (in_word),
        .in_key_load (in_key_load),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_word    (out_word)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        stim_rng = lcg_step(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [BLOCK_W-1:0] rand_key();
        logic [BLOCK_W-1:0] k;
        for (int i = 0; i < BLOCK_W / 32; i++) begin
            k[i*32 +: 32] = rand32();
        end
        return k;
    endfunction

    function automatic logic [WORD_W-1:0] rand_data();
        logic [WORD_W-1:0] d;
        for (int i = 0; i < WORD_W / 32; i++) begin
            d[i*32 +: 32] = rand32();
        end
        return d;
    endfunction

    // bytes 0 to nbytes-1 kept
    function automatic logic [WORD_BYTES-1:0] keep_mask(input int nbytes);
        logic [WORD_BYTES-1:0] mask;
        mask = '0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            mask[i] = (i < nbytes);
        end
        return mask;
    endfunction

    task automatic report_failure(input string reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_idle_outputs();
        assert (out_valid === 1'b0) else begin
            $display("** Error: out_valid expected %h, got %h", 1'b0, out_valid);
            report_failure("wrong out_valid around reset");
        end
        assert (in_ready === 1'b1) else begin
            $display("** Error: in_ready expected %h, got %h", 1'b1, in_ready);
            report_failure("wrong in_ready around reset");
        end
    endtask

    // hold the word until in_ready is seen high at a rising edge
    task automatic send_word(input stream_word_t w, input logic key_load);
        logic accepted;
        @(negedge aclk);
        in_valid    = 1'b1;
        in_word     = w;
        in_key_load = key_load;
        accepted    = 1'b0;
        while (!accepted) begin
            #(CLK_PERIOD / 4);
            accepted = in_ready;
            @(posedge aclk);
        end
    endtask

    task automatic release_input();
        @(negedge aclk);
        in_valid    = 1'b0;
        in_key_load = 1'b0;
    endtask

    task automatic load_key(input logic [31:0] idx, input logic [BLOCK_W-1:0] key);
        in_word_u     view;
        stream_word_t w;
        view                  = '0;
        view.key_load.key_idx = idx;
        view.key_load.key     = key;
        w.data = view.raw;
        w.keep = '1;
        w.last = 1'b0;
        // only the low index bits pick the table entry
        key_model[idx % NUM_KEYS] = key;
        send_word(w, 1'b1);
    endtask

    task automatic send_message(input logic [31:0] idx, input int n_words, input int last_bytes);
        in_word_u           view;
        stream_word_t       hdr;
        stream_word_t       pay [MAX_PAYLOAD];
        stream_word_t       acc;
        logic [BLOCK_W-1:0] key;
        logic               is_final;
        int                 slot;
        view              = '0;
        view.hdr.cmd_id   = rand32();
        view.hdr.cmd_len  = rand32();
        view.hdr.dst      = idx;
        view.hdr.src      = rand32();
        view.hdr.tag      = rand32();
        view.hdr.data_len = (n_words - 1) * WORD_BYTES + last_bytes;
        hdr.data = view.raw;
        hdr.keep = '1;
        hdr.last = 1'b0;
        exp_q.push_back(hdr);

        key  = key_model[idx % NUM_KEYS];
        acc  = '0;
        slot = 0;
        for (int w = 0; w < n_words; w++) begin
            pay[w].data = rand_data();
            pay[w].keep = (w == n_words - 1) ? keep_mask(last_bytes) : '1;
            pay[w].last = (w == n_words - 1);
            for (int b = 0; b < BLOCKS_PER_WORD; b++) begin
                if (|pay[w].keep[b*BLOCK_BYTES +: BLOCK_BYTES]) begin
                    is_final = pay[w].last && (b == (last_bytes - 1) / BLOCK_BYTES);
                    acc.data[slot*BLOCK_W +: BLOCK_W] =
                        pay[w].data[b*BLOCK_W +: BLOCK_W] ^ key;
                    acc.keep[slot*BLOCK_BYTES +: BLOCK_BYTES] =
                        pay[w].keep[b*BLOCK_BYTES +: BLOCK_BYTES];
                    slot++;
                    if (slot == BLOCKS_PER_WORD || is_final) begin
                        acc.last = is_final;
                        exp_q.push_back(acc);
                        acc  = '0;
                        slot = 0;
                    end
                end
            end
        end

        send_word(hdr, 1'b0);
        for (int w = 0; w < n_words; w++) begin
            send_word(pay[w], 1'b0);
        end
    endtask

    // wait for every expected word, but not longer than DRAIN_CYCLES
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < DRAIN_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
    endtask

    // random out_ready during the back-pressure test
    always @(negedge aclk) begin
        if (random_ready) begin
            ready_rng = lcg_step(ready_rng);
            out_ready = ready_rng[16];
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge aclk) begin
        if (aresetn === 1'b1) begin
            if (hold_pending) begin
                assert (out_valid === 1'b1) else begin
                    $display("** Error: out_valid expected %h, got %h", 1'b1, out_valid);
                    report_failure("out_valid dropped while the output was stalled");
                end
                assert (out_word === held_word) else begin
                    $display("** Error: out_word expected %h, got %h", held_word, out_word);
                    report_failure("out_word changed while the output was stalled");
                end
            end
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                assert (exp_q.size() != 0) else begin
                    report_failure("the DUT produced an output word that was not expected");
                end
                exp_w = exp_q.pop_front();
                assert (out_word.data === exp_w.data) else begin
                    $display("** Error: out_word.data expected %h, got %h",
                             exp_w.data, out_word.data);
                    report_failure("output data mismatch");
                end
                assert (out_word.keep === exp_w.keep) else begin
                    $display("** Error: out_word.keep expected %h, got %h",
                             exp_w.keep, out_word.keep);
                    report_failure("output keep mismatch");
                end
                assert (out_word.last === exp_w.last) else begin
                    $display("** Error: out_word.last expected %h, got %h",
                             exp_w.last, out_word.last);
                    report_failure("output last mismatch");
                end
                words_checked++;
            end
            hold_pending = (out_valid === 1'b1) && (out_ready !== 1'b1);
            held_word    = out_word;
        end else begin
            hold_pending = 1'b0;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("the run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
        report_failure("timeout");
    end

    initial begin
        logic [31:0] msg_idx;
        int          n_words;
        int          last_bytes;
        aclk          = 1'b0;
        aresetn       = 1'b0;
        in_valid      = 1'b0;
        in_word       = '0;
        in_key_load   = 1'b0;
        out_ready     = 1'b1;
        random_ready  = 1'b0;
        stim_rng      = SEED;
        ready_rng     = lcg_step(~SEED);
        hold_pending  = 1'b0;
        words_checked = 0;
        for (int i = 0; i < NUM_KEYS; i++) begin
            key_model[i] = '0;
        end

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge aclk);
            #(CLK_PERIOD / 4);
            if (c > 0) begin
                check_idle_outputs();
            end
        end
        @(negedge aclk);
        aresetn = 1'b1;
        @(posedge aclk);
        #(CLK_PERIOD / 4);
        check_idle_outputs();

        // one message with two full payload words
        load_key(32'd3, rand_key());
        send_message(32'd3, 2, WORD_BYTES);
        release_input();
        wait_drain();

        // last payload word keeps 20 bytes
        load_key(32'd5, rand_key());
        send_message(32'd5, 2, 20);
        release_input();
        wait_drain();

        // index 9 starts with a zero key, then gets a real one
        send_message(32'd9, 2, WORD_BYTES);
        release_input();
        wait_drain();
        load_key(32'd9, rand_key());
        send_message(32'd9, 2, 48);
        release_input();
        wait_drain();

        // back-to-back messages under random back-pressure
        random_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            load_key(32'(10 + k), rand_key());
        end
        for (int m = 0; m < BP_MESSAGES; m++) begin
            msg_idx    = (rand32() & 32'hffff_fff0) | 32'(10 + m % 4);
            n_words    = 1 + int'(rand32() % MAX_PAYLOAD);
            last_bytes = 1 + int'(rand32() % WORD_BYTES);
            send_message(msg_idx, n_words, last_bytes);
        end
        release_input();
        wait_drain();
        random_ready = 1'b0;
        repeat (20) @(posedge aclk);

        $display("%0d output words checked", words_checked);
        if (exp_q.size() != 0) begin
            report_failure("expected output words were never produced");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* files.f */
design/auth_pkg.sv
design/stream_fifo.sv
design/msg_splitter.sv
design/key_table.sv
design/block_unpacker.sv
design/key_mixer.sv
design/packet_merger.sv
design/auth_pipe.sv
tests/tb_auth_pipe.sv
